//--- hw/led_matrix_pkg.sv
`default_nettype none

package led_matrix_pkg;

  // matrix geometry
  localparam int max_pixels = 64;

  // pixel index and offset width, 6 bits for an 8x8 matrix
  localparam int pixel_width = $clog2(max_pixels);

  // request queue depth, also the host's starting credit count
  localparam int req_depth = 4;

  // byte queue depth, also the sequencer's starting credit count
  localparam int byte_depth = 4;

  // width of the sequencer's byte credit counter (0 .. byte_depth)
  localparam int byte_credit_width = $clog2(byte_depth + 1);

  // command byte that rewinds the matrix frame index
  localparam logic [7:0] cmd_reset_frame_index = 8'h26;

  // one frame request from the host
  typedef struct packed {
    // added to every pixel index, wraps modulo max_pixels
    logic [pixel_width-1:0] offset;
    // pixel count minus one
    logic [pixel_width-1:0] last_pixel;
  } frame_req_t;

  // one byte on its way to the SPI transmitter
  typedef struct packed {
    logic [7:0] data;
    // release chip select once this byte is out
    logic       end_cs;
  } spi_byte_t;

endpackage

`default_nettype wire

//--- hw/credit_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module credit_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int  depth     = 4
) (
  input  logic     clock,
  input  logic     reset,
  input  logic     push,
  input  payload_t din,
  input  logic     pop,
  output payload_t dout,
  output logic     head_valid,
  output logic     credit
);

  localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
  localparam int cnt_w = $clog2(depth + 1);

  payload_t           mem [depth];
  logic [ptr_w-1:0]   rd_ptr;
  logic [ptr_w-1:0]   wr_ptr;
  logic [cnt_w-1:0]   count;
  logic               do_push;
  logic               do_pop;

  // a push into a full queue is dropped
  assign do_push    = push && (count != cnt_w'(depth));
  assign do_pop     = pop && (count != '0);
  assign head_valid = (count != '0);
  assign dout       = mem[rd_ptr];

  // storage
  always_ff @(posedge clock) begin
    if (do_push) begin
      mem[wr_ptr] <= din;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
      credit <= 1'b0;
    end else begin
      // one credit back to the producer per pop
      credit <= do_pop;
      if (do_push) begin
        wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- hw/spi_byte_tx.sv
`timescale 1ns/100ps
`default_nettype none

module spi_byte_tx import led_matrix_pkg::*; (
  input  logic      clock,
  input  logic      reset,
  input  spi_byte_t byte_in,
  input  logic      byte_valid,
  output logic      byte_pop,
  output logic      sclk,
  output logic      mosi,
  output logic      n_cs
);

  typedef enum logic [1:0] {
    st_idle,
    st_cs_setup,
    st_shift,
    st_cs_hold
  } state_t;

  state_t     state;
  logic [7:0] shift_reg;
  logic [2:0] bit_cnt;
  // low half of a bit period when clear, sclk high half when set
  logic       phase;
  logic       end_cs_q;
  logic       bit_done;
  logic       byte_done;

  // take the head of the byte queue whenever nothing is in flight
  assign byte_pop  = (state == st_idle) && byte_valid;
  assign bit_done  = (state == st_shift) && phase;
  assign byte_done = bit_done && (bit_cnt == 3'd7);

  // byte payload, msb first
  always_ff @(posedge clock) begin
    if (byte_pop) begin
      shift_reg <= byte_in.data;
      end_cs_q  <= byte_in.end_cs;
    end else if (bit_done) begin
      shift_reg <= {shift_reg[6:0], 1'b0};
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state   <= st_idle;
      bit_cnt <= '0;
      phase   <= 1'b0;
      sclk    <= 1'b0;
      mosi    <= 1'b0;
      n_cs    <= 1'b1;
    end else begin
      case (state)
        st_idle: begin
          if (byte_valid) begin
            // first bit goes out while sclk is still low
            mosi    <= byte_in.data[7];
            bit_cnt <= '0;
            phase   <= 1'b0;
            if (n_cs) begin
              n_cs  <= 1'b0;
              state <= st_cs_setup;
            end else begin
              // chip select still held from the previous byte
              state <= st_shift;
            end
          end
        end

        st_cs_setup: begin
          state <= st_shift;
        end

        st_shift: begin
          if (!phase) begin
            // rising edge, slave samples mosi here
            sclk  <= 1'b1;
            phase <= 1'b1;
          end else begin
            sclk    <= 1'b0;
            phase   <= 1'b0;
            // next bit, zero once the last bit has left
            mosi    <= shift_reg[6];
            bit_cnt <= bit_cnt + 1'b1;
            if (byte_done) begin
              state <= end_cs_q ? st_cs_hold : st_idle;
            end
          end
        end

        st_cs_hold: begin
          n_cs  <= 1'b1;
          state <= st_idle;
        end

        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- hw/frame_sequencer.sv
`timescale 1ns/100ps
`default_nettype none

module frame_sequencer import led_matrix_pkg::*; (
  input  logic       clock,
  input  logic       reset,
  input  frame_req_t req,
  input  logic       req_valid,
  input  logic       byte_credit,
  output logic       req_pop,
  output logic       byte_push,
  output spi_byte_t  byte_out
);

  typedef enum logic [1:0] {
    st_idle,
    st_command,
    st_pixels
  } state_t;

  state_t                       state;
  frame_req_t                   req_q;
  logic [pixel_width-1:0]       pixel_idx;
  logic [pixel_width-1:0]       pixel_val;
  logic [byte_credit_width-1:0] credits;
  logic                         has_credit;
  logic                         at_last_pixel;

  assign has_credit    = (credits != '0);
  assign req_pop       = (state == st_idle) && req_valid;
  // every byte waits for a free slot in the byte queue
  assign byte_push     = ((state == st_command) || (state == st_pixels)) && has_credit;
  // the sum wraps on its own at pixel_width bits, i.e. modulo max_pixels
  assign pixel_val     = pixel_idx + req_q.offset;
  assign at_last_pixel = (pixel_idx == req_q.last_pixel);

  always_comb begin
    if (state == st_command) begin
      // command sits alone in its own chip-select frame
      byte_out.data   = cmd_reset_frame_index;
      byte_out.end_cs = 1'b1;
    end else begin
      byte_out.data   = 8'(pixel_val);
      byte_out.end_cs = at_last_pixel;
    end
  end

  // latched request
  always_ff @(posedge clock) begin
    if (req_pop) begin
      req_q <= req;
    end
  end

  // byte queue credits, one spent per push, one back per pop downstream
  always_ff @(posedge clock) begin
    if (reset) begin
      credits <= byte_credit_width'(byte_depth);
    end else begin
      case ({byte_push, byte_credit})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state     <= st_idle;
      pixel_idx <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (req_valid) begin
            pixel_idx <= '0;
            state     <= st_command;
          end
        end

        st_command: begin
          if (has_credit) begin
            state <= st_pixels;
          end
        end

        st_pixels: begin
          // stall in place while out of credits
          if (has_credit) begin
            if (at_last_pixel) begin
              state <= st_idle;
            end else begin
              pixel_idx <= pixel_idx + 1'b1;
            end
          end
        end

        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- hw/led_matrix_top.sv
`timescale 1ns/100ps
`default_nettype none

module led_matrix_top import led_matrix_pkg::*; (
  input  logic       clock,
  input  logic       reset,
  input  logic       req_valid,
  input  frame_req_t req,
  output logic       req_credit,
  output logic       sclk,
  output logic       mosi,
  output logic       n_cs
);

  // request queue to sequencer
  frame_req_t req_head;
  logic       req_head_valid;
  logic       req_pop;

  // sequencer to byte queue
  spi_byte_t  seq_byte;
  logic       seq_byte_push;
  logic       byte_credit;

  // byte queue to transmitter
  spi_byte_t  tx_byte;
  logic       tx_byte_valid;
  logic       tx_byte_pop;

  // host requests, credits go straight back to the host
  credit_fifo #(
    .payload_t (frame_req_t),
    .depth     (req_depth)
  ) u_req_fifo (
    .clock      (clock),
    .reset      (reset),
    .push       (req_valid),
    .din        (req),
    .pop        (req_pop),
    .dout       (req_head),
    .head_valid (req_head_valid),
    .credit     (req_credit)
  );

  frame_sequencer u_sequencer (
    .clock       (clock),
    .reset       (reset),
    .req         (req_head),
    .req_valid   (req_head_valid),
    .byte_credit (byte_credit),
    .req_pop     (req_pop),
    .byte_push   (seq_byte_push),
    .byte_out    (seq_byte)
  );

  credit_fifo #(
    .payload_t (spi_byte_t),
    .depth     (byte_depth)
  ) u_byte_fifo (
    .clock      (clock),
    .reset      (reset),
    .push       (seq_byte_push),
    .din        (seq_byte),
    .pop        (tx_byte_pop),
    .dout       (tx_byte),
    .head_valid (tx_byte_valid),
    .credit     (byte_credit)
  );

  spi_byte_tx u_spi_tx (
    .clock      (clock),
    .reset      (reset),
    .byte_in    (tx_byte),
    .byte_valid (tx_byte_valid),
    .byte_pop   (tx_byte_pop),
    .sclk       (sclk),
    .mosi       (mosi),
    .n_cs       (n_cs)
  );

endmodule

`default_nettype wire

//--- bench/tb_clock_gen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen (
  output logic clock,
  output logic reset
);

  // 40 ns period
  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  initial begin
    reset = 1'b1;
    repeat (5) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
  end

endmodule

`default_nettype wire

//--- bench/spi_frame_checker.sv
`timescale 1ns/100ps
`default_nettype none

module spi_frame_checker (
  input wire logic sclk,
  input wire logic mosi,
  input wire logic n_cs
);

  typedef struct packed {
    logic [5:0]  offset;
    logic [6:0]  count;
    logic [7:0]  last_byte;
    logic [15:0] sum;
  } frame_exp_t;

  // expected frames, filled by the testbench top in request order
  frame_exp_t exp_q[$];
  logic [7:0] rx_q[$];
  logic [7:0] shift_in;
  int         bit_cnt = 0;
  int         errors = 0;
  int         frames_done = 0;
  // every request starts with a command frame
  bit         want_cmd = 1'b1;
  // set once chip select has fallen
  bit         in_frame = 1'b0;

  always @(negedge n_cs) begin
    rx_q.delete();
    bit_cnt  = 0;
    in_frame = 1'b1;
  end

  // mode 0, slave samples on the rising sclk edge
  always @(posedge sclk) begin
    shift_in = {shift_in[6:0], mosi};
    bit_cnt  = bit_cnt + 1;
    if (bit_cnt == 8) begin
      rx_q.push_back(shift_in);
      bit_cnt = 0;
    end
  end

  always @(posedge n_cs) begin
    frame_exp_t e;
    int         sum;
    int         exp_b;
    // the rise out of reset closes no frame
    if (in_frame) begin
      in_frame = 1'b0;
      if (bit_cnt != 0) begin
        $display("chip select rose in the middle of a byte after %0d bits", bit_cnt);
        errors = errors + 1;
      end
      if (want_cmd) begin
        if (rx_q.size() != 1) begin
          $display("CHECK FAILED command frame size: got 0x%0h expected 0x1", rx_q.size());
          errors = errors + 1;
        end else if (rx_q[0] != 8'h26) begin
          $display("CHECK FAILED command byte mosi: got 0x%02h expected 0x26", rx_q[0]);
          errors = errors + 1;
        end
      end else if (exp_q.size() == 0) begin
        $display("a pixel frame arrived with no request waiting for it");
        errors = errors + 1;
      end else begin
        e   = exp_q.pop_front();
        sum = 0;
        if (rx_q.size() != int'(e.count)) begin
          $display("CHECK FAILED pixel frame size: got 0x%0h expected 0x%0h",
                   rx_q.size(), e.count);
          errors = errors + 1;
        end
        foreach (rx_q[i]) begin
          exp_b = (int'(e.offset) + i) % 64;
          sum   = sum + int'(rx_q[i]);
          if (int'(rx_q[i]) != exp_b) begin
            $display("CHECK FAILED pixel %0d mosi: got 0x%02h expected 0x%02h",
                     i, rx_q[i], exp_b[7:0]);
            errors = errors + 1;
          end
        end
        if (rx_q.size() > 0 && rx_q[rx_q.size() - 1] != e.last_byte) begin
          $display("CHECK FAILED last pixel mosi: got 0x%02h expected 0x%02h",
                   rx_q[rx_q.size() - 1], e.last_byte);
          errors = errors + 1;
        end
        if (sum[15:0] != e.sum) begin
          $display("CHECK FAILED pixel sum: got 0x%04h expected 0x%04h", sum[15:0], e.sum);
          errors = errors + 1;
        end
      end
      want_cmd    = !want_cmd;
      frames_done = frames_done + 1;
    end
  end

endmodule

`default_nettype wire

//--- bench/led_matrix_asserts.sv
`timescale 1ns/100ps
`default_nettype none

module led_matrix_asserts (
  input wire logic clock,
  input wire logic reset,
  input wire logic sclk,
  input wire logic n_cs,
  input wire logic byte_pop
);

  // no clock activity outside a chip-select frame
  a_sclk_low_cs_high: assert property (@(posedge clock) disable iff (reset)
    n_cs |-> !sclk) else $error("sclk high while n_cs is high");

  a_rise_in_frame: assert property (@(posedge clock) disable iff (reset)
    $rose(sclk) |-> !n_cs) else $error("sclk rose outside a frame");

  // one setup cycle between chip select falling and the first sclk edge
  a_cs_setup: assert property (@(posedge clock) disable iff (reset)
    $fell(n_cs) |=> !sclk) else $error("sclk rose right after n_cs fell");

  // one pop per byte, so one byte credit back per byte sent
  a_single_pop: assert property (@(posedge clock) disable iff (reset)
    byte_pop |=> !byte_pop) else $error("byte queue popped twice in a row");

endmodule

bind spi_byte_tx led_matrix_asserts u_asserts (
  .clock      (clock),
  .reset      (reset),
  .sclk       (sclk),
  .n_cs       (n_cs),
  .byte_pop   (byte_pop)
);

`default_nettype wire

//--- bench/led_matrix_tb.sv
`timescale 1ns/100ps
`default_nettype none

module led_matrix_tb import led_matrix_pkg::*; ();

  logic       clock;
  logic       reset;
  logic       req_valid;
  frame_req_t req;
  logic       req_credit;
  logic       sclk;
  logic       mosi;
  logic       n_cs;

  int         offs[$];
  int         cnts[$];
  int         seed = 34;
  int         host_credits = req_depth;
  int         credit_pulses = 0;
  int         issued = 0;
  int         tb_errors = 0;
  int         limit_cycles = 2000;

  tb_clock_gen clk_gen (.clock(clock), .reset(reset));

  led_matrix_top uut (
    .clock      (clock),
    .reset      (reset),
    .req_valid  (req_valid),
    .req        (req),
    .req_credit (req_credit),
    .sclk       (sclk),
    .mosi       (mosi),
    .n_cs       (n_cs)
  );

  spi_frame_checker chk (.sclk(sclk), .mosi(mosi), .n_cs(n_cs));

  // reads offset, count, last byte and sum per line, all hex
  task automatic load_requests();
    int    fd;
    int    off_i;
    int    cnt_i;
    int    last_i;
    int    sum_i;
    string line;
    fd = $fopen("bench/frame_stimulus.txt", "r");
    if (fd == 0) begin
      $display("cannot open bench/frame_stimulus.txt");
      $display("ERRORS FOUND");
      $finish;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() > 1 && line.getc(0) != 8'h23) begin
          if ($sscanf(line, "%h %h %h %h", off_i, cnt_i, last_i, sum_i) == 4) begin
            offs.push_back(off_i);
            cnts.push_back(cnt_i);
            chk.exp_q.push_back({6'(off_i), 7'(cnt_i), 8'(last_i), 16'(sum_i)});
            limit_cycles = limit_cycles + (cnt_i + 1) * 40;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  initial begin
    req_valid = 1'b0;
    req       = '0;
    load_requests();
    fork
      begin
        repeat (limit_cycles) @(posedge clock);
        $display("watchdog expired before all frames were sent");
        $display("ERRORS FOUND");
        $finish;
      end
    join_none
    @(negedge reset);
    // idle bus before the first request
    repeat (4) begin
      @(negedge clock);
      if (n_cs !== 1'b1 || sclk !== 1'b0) begin
        $display("CHECK FAILED idle n_cs/sclk: got 0x%h/0x%h expected 0x1/0x0", n_cs, sclk);
        tb_errors = tb_errors + 1;
      end
    end
    while (chk.frames_done < 2 * offs.size()) begin
      @(negedge clock);
      if (req_credit) begin
        host_credits  = host_credits + 1;
        credit_pulses = credit_pulses + 1;
      end
      if (host_credits > req_depth) begin
        $display("host credits went above the queue depth");
        tb_errors = tb_errors + 1;
      end
      req_valid = 1'b0;
      if (issued < offs.size() && host_credits > 0 && ($random(seed) & 3) != 0) begin
        req.offset     = 6'(offs[issued]);
        req.last_pixel = 6'(cnts[issued] - 1);
        req_valid      = 1'b1;
        host_credits   = host_credits - 1;
        issued         = issued + 1;
      end
    end
    req_valid = 1'b0;
    repeat (10) @(negedge clock);
    if (credit_pulses != issued) begin
      $display("CHECK FAILED req_credit pulses: got 0x%0h expected 0x%0h",
               credit_pulses, issued);
      tb_errors = tb_errors + 1;
    end
    $display("checker errors %0d, testbench errors %0d", chk.errors, tb_errors);
    if (chk.errors + tb_errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- bench/frame_stimulus.txt
# columns (hex): offset  pixel_count  last_pixel_byte  byte_sum
# one request per line, sent in order
00 01 00 0000
05 04 08 001a
3e 04 01 007e
00 40 3f 07e0
20 40 1f 07e0
3f 02 00 003f
10 08 17 009c
2a 01 2a 002a
30 20 0f 03f0
01 03 03 0006

//--- src.f
hw/led_matrix_pkg.sv
hw/credit_fifo.sv
hw/spi_byte_tx.sv
hw/frame_sequencer.sv
hw/led_matrix_top.sv
bench/tb_clock_gen.sv
bench/spi_frame_checker.sv
bench/led_matrix_asserts.sv
bench/led_matrix_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module led_matrix_tb -f src.f -o led_matrix_sim

# an assertion abort leaves no closing message, caught by the checks below
./obj_dir/led_matrix_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "ERRORS FOUND" sim.log; then
  echo "simulation failed"
  exit 1
fi
if ! grep -q "NO ERRORS" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi
echo "simulation passed"
